// File: hw/ooo_config.svh
// sizes for the dispatch and issue block
// ROB_LEN must be a power of two, tags wrap by plain overflow
// RS_LEN above 1 assumed, slot index is $clog2 wide

`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// reservation station slots
`define RS_LEN 4

// reorder buffer tags in flight
`define ROB_LEN 8

// data word width
`define XLEN 32

// architectural registers, r0 hardwired to zero
`define ARCH_REGS 32

`endif

// File: hw/ooo_pkg.sv
// shared types for the dispatch and issue block
// widths follow ooo_config.svh, change sizes there only

package ooo_pkg;

    `include "ooo_config.svh"

    //////////////////////////////
    // indices and data
    //////////////////////////////

    // rob index, also the age key for issue
    typedef logic [$clog2(`ROB_LEN)-1:0] rob_tag_t;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t; // r0 = zero reg

    typedef logic [`XLEN-1:0] xlen_t;

    // rs slot index
    typedef logic [$clog2(`RS_LEN)-1:0] rs_slot_t;

    // carried through to execute, not evaluated here
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_XOR = 2'b11
    } alu_op_t;

    //////////////////////////////
    // rename and operand state
    //////////////////////////////

    typedef struct packed {
        logic     pending; // producer still in flight
        rob_tag_t tag;     // producer rob tag
    } map_entry_t;

    typedef struct packed {
        logic     ready; // value valid
        rob_tag_t tag;   // tag to watch on cdb while not ready
        xlen_t    value;
    } operand_t;

endpackage

// File: hw/rob_tag_ring.sv
// rob tag allocator, head and tail pointers plus occupancy
// retire must only be given when the rob is not empty
// alloc is expected to be held off by rob_full upstream

`timescale 1ns/10ps

`include "ooo_config.svh"

module rob_tag_ring (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               squash,
    input  logic               alloc,     // accepted dispatch
    input  logic               retire,    // free head tag
    output ooo_pkg::rob_tag_t  alloc_tag, // next tag handed out
    output ooo_pkg::rob_tag_t  head_tag,  // oldest live tag
    output logic               rob_full
);

    ooo_pkg::rob_tag_t           head;
    ooo_pkg::rob_tag_t           tail;
    logic [$clog2(`ROB_LEN):0]   count; // one extra bit to reach ROB_LEN

    //////////////////////////////
    // pointers
    //////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
        end else if (squash) begin
            head <= '0; // restart numbering
            tail <= '0;
        end else begin
            if (alloc)
                tail <= tail + 1'b1; // wraps by overflow
            if (retire)
                head <= head + 1'b1;
        end
    end

    // occupancy, both strobes cancel out
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (squash) begin
            count <= '0;
        end else if (alloc && !retire) begin
            count <= count + 1'b1;
        end else if (retire && !alloc) begin
            count <= count - 1'b1;
        end
    end

    assign alloc_tag = tail;
    assign head_tag  = head;
    assign rob_full  = (count == `ROB_LEN); // all tags unretired

endmodule

// File: hw/map_table.sv
// rename map, one pending producer tag per architectural register
// r0 never goes pending, reads of r0 always come back not pending
// dispatch beats a cdb clear on the same register at the same edge

`timescale 1ns/10ps

`include "ooo_config.svh"

module map_table (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 squash,
    input  logic                 dispatch_fire,
    input  ooo_pkg::arch_reg_t   dispatch_rs1,
    input  ooo_pkg::arch_reg_t   dispatch_rs2,
    input  ooo_pkg::arch_reg_t   dispatch_rd,
    input  ooo_pkg::rob_tag_t    alloc_tag,
    input  logic                 cdb_valid,
    input  ooo_pkg::rob_tag_t    cdb_tag,
    output ooo_pkg::map_entry_t  rs1_map,
    output ooo_pkg::map_entry_t  rs2_map
);

    logic [`ARCH_REGS-1:0] pending;
    ooo_pkg::rob_tag_t     tags [`ARCH_REGS]; // only meaningful while pending

    logic rd_write; // dest rename this cycle
    assign rd_write = dispatch_fire && (dispatch_rd != '0);

    // pending bits
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else if (squash) begin
            pending <= '0; // flush all renames
        end else begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                if (rd_write && dispatch_rd == ooo_pkg::arch_reg_t'(i))
                    pending[i] <= 1'b1; // newest producer wins
                else if (cdb_valid && pending[i] && tags[i] == cdb_tag)
                    pending[i] <= 1'b0; // producer written back
            end
        end
    end

    // tag storage
    always_ff @(posedge clock) begin
        if (rd_write)
            tags[dispatch_rd] <= alloc_tag;
    end

    //////////////////////////////
    // source lookup, comb
    //////////////////////////////

    always_comb begin
        rs1_map.pending = (dispatch_rs1 != '0) && pending[dispatch_rs1];
        rs1_map.tag     = tags[dispatch_rs1];
        rs2_map.pending = (dispatch_rs2 != '0) && pending[dispatch_rs2];
        rs2_map.tag     = tags[dispatch_rs2];
    end

endmodule

// File: hw/rs_entry.sv
// one reservation station slot
// wr_en beats clear so a slot can be freed and refilled in one cycle
// operand fields are only meaningful while busy

`timescale 1ns/10ps

module rs_entry (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                squash,
    input  logic                wr_en,   // load a dispatched instr
    input  logic                clear,   // issued, free the slot
    input  ooo_pkg::alu_op_t    op_in,
    input  ooo_pkg::arch_reg_t  rd_in,
    input  ooo_pkg::rob_tag_t   tag_in,
    input  ooo_pkg::operand_t   rs1_in,
    input  ooo_pkg::operand_t   rs2_in,
    input  logic                cdb_valid,
    input  ooo_pkg::rob_tag_t   cdb_tag,
    input  ooo_pkg::xlen_t      cdb_value,
    output logic                busy,
    output logic                ready,
    output ooo_pkg::alu_op_t    op,
    output ooo_pkg::arch_reg_t  rd,
    output ooo_pkg::rob_tag_t   rob_tag,
    output ooo_pkg::operand_t   rs1,
    output ooo_pkg::operand_t   rs2,
    output logic                rs1_hit, // rs1 takes the cdb this cycle
    output logic                rs2_hit
);

    //////////////////////////////
    // wakeup
    //////////////////////////////

    // an operand waiting on the broadcast tag
    assign rs1_hit = cdb_valid && !rs1.ready && (rs1.tag == cdb_tag);
    assign rs2_hit = cdb_valid && !rs2.ready && (rs2.tag == cdb_tag);

    // ready counts a same-cycle hit, issue forwards the cdb value
    assign ready = busy
                && (rs1.ready || rs1_hit)
                && (rs2.ready || rs2_hit);

    // occupancy
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (squash) begin
            busy <= 1'b0;
        end else if (wr_en) begin
            busy <= 1'b1; // refill wins over issue clear
        end else if (clear) begin
            busy <= 1'b0;
        end
    end

    // payload, loaded on write, operands updated by cdb capture
    always_ff @(posedge clock) begin
        if (wr_en) begin
            op      <= op_in;
            rd      <= rd_in;
            rob_tag <= tag_in;
            rs1     <= rs1_in;
            rs2     <= rs2_in;
        end else begin
            if (rs1_hit) begin
                rs1.ready <= 1'b1;
                rs1.value <= cdb_value;
            end
            if (rs2_hit) begin
                rs2.ready <= 1'b1;
                rs2.value <= cdb_value;
            end
        end
    end

endmodule

// File: hw/rs.sv
// reservation station, dispatch slot choice and single issue select
// issue picks the ready entry with rob tag closest above head_tag
// issue is comb from registered entries, earliest one cycle after dispatch
// is_stall holds the chosen entry, it is picked again later

`timescale 1ns/10ps

`include "ooo_config.svh"

module rs (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 squash,
    input  logic                 stall,    // blocks dispatch only
    input  logic                 is_stall, // keeps issued entry in place
    input  logic                 dispatch_valid,
    input  ooo_pkg::alu_op_t     dispatch_op,
    input  ooo_pkg::arch_reg_t   dispatch_rs1,
    input  ooo_pkg::arch_reg_t   dispatch_rs2,
    input  ooo_pkg::arch_reg_t   dispatch_rd,
    input  ooo_pkg::xlen_t       dispatch_rs1_value,
    input  ooo_pkg::xlen_t       dispatch_rs2_value,
    input  ooo_pkg::map_entry_t  rs1_map,
    input  ooo_pkg::map_entry_t  rs2_map,
    input  ooo_pkg::rob_tag_t    alloc_tag,
    input  ooo_pkg::rob_tag_t    head_tag,
    input  logic                 rob_full,
    input  logic                 cdb_valid,
    input  ooo_pkg::rob_tag_t    cdb_tag,
    input  ooo_pkg::xlen_t       cdb_value,
    output logic                 dispatch_fire,
    output logic                 dispatch_ready,
    output logic                 issue_valid,
    output ooo_pkg::alu_op_t     issue_op,
    output ooo_pkg::arch_reg_t   issue_rd,
    output ooo_pkg::rob_tag_t    issue_rob_tag,
    output ooo_pkg::xlen_t       issue_rs1_value,
    output ooo_pkg::xlen_t       issue_rs2_value
);

    logic [`RS_LEN-1:0]  wr_en, clear, busy, ready, rs1_hit, rs2_hit;
    ooo_pkg::alu_op_t    e_op  [`RS_LEN];
    ooo_pkg::arch_reg_t  e_rd  [`RS_LEN];
    ooo_pkg::rob_tag_t   e_tag [`RS_LEN];
    ooo_pkg::rob_tag_t   age   [`RS_LEN]; // distance from rob head
    ooo_pkg::operand_t   e_rs1 [`RS_LEN];
    ooo_pkg::operand_t   e_rs2 [`RS_LEN];
    ooo_pkg::operand_t   rs1_op, rs2_op;   // dispatch operands
    ooo_pkg::rs_slot_t   issue_slot, disp_slot;
    ooo_pkg::rob_tag_t   best_age;
    logic                any_ready, issue_fire, slot_found;

    //////////////////////////////
    // dispatch operands
    //////////////////////////////

    // pending source may be woken by the cdb in the dispatch cycle
    always_comb begin
        rs1_op.tag   = rs1_map.tag;
        rs1_op.ready = !rs1_map.pending || (cdb_valid && cdb_tag == rs1_map.tag);
        rs1_op.value = rs1_map.pending ? cdb_value : dispatch_rs1_value;
        rs2_op.tag   = rs2_map.tag;
        rs2_op.ready = !rs2_map.pending || (cdb_valid && cdb_tag == rs2_map.tag);
        rs2_op.value = rs2_map.pending ? cdb_value : dispatch_rs2_value;
    end

    for (genvar g = 0; g < `RS_LEN; g++) begin : g_entry
        rs_entry rs_entry_inst (
            .clock     (clock),
            .arst_n    (arst_n),
            .squash    (squash),
            .wr_en     (wr_en[g]),
            .clear     (clear[g]),
            .op_in     (dispatch_op),
            .rd_in     (dispatch_rd),
            .tag_in    (alloc_tag),
            .rs1_in    (rs1_op),
            .rs2_in    (rs2_op),
            .cdb_valid (cdb_valid),
            .cdb_tag   (cdb_tag),
            .cdb_value (cdb_value),
            .busy      (busy[g]),
            .ready     (ready[g]),
            .op        (e_op[g]),
            .rd        (e_rd[g]),
            .rob_tag   (e_tag[g]),
            .rs1       (e_rs1[g]),
            .rs2       (e_rs2[g]),
            .rs1_hit   (rs1_hit[g]),
            .rs2_hit   (rs2_hit[g])
        );
        assign age[g] = e_tag[g] - head_tag; // wraps in tag width
    end

    //////////////////////////////
    // issue select, oldest first
    //////////////////////////////

    always_comb begin
        any_ready  = 1'b0;
        issue_slot = '0;
        best_age   = '0;
        for (int i = 0; i < `RS_LEN; i++) begin
            if (ready[i] && (!any_ready || age[i] < best_age)) begin
                any_ready  = 1'b1;
                issue_slot = ooo_pkg::rs_slot_t'(i);
                best_age   = age[i];
            end
        end
    end

    assign issue_fire      = any_ready && !is_stall;
    assign issue_valid     = issue_fire;
    assign issue_op        = e_op[issue_slot];
    assign issue_rd        = e_rd[issue_slot];
    assign issue_rob_tag   = e_tag[issue_slot];
    // forward the broadcast into an operand woken this cycle
    assign issue_rs1_value = rs1_hit[issue_slot] ? cdb_value : e_rs1[issue_slot].value;
    assign issue_rs2_value = rs2_hit[issue_slot] ? cdb_value : e_rs2[issue_slot].value;

    //////////////////////////////
    // dispatch slot choice
    //////////////////////////////

    always_comb begin
        slot_found = 1'b0;
        disp_slot  = '0;
        for (int i = `RS_LEN-1; i >= 0; i--) begin // ends on lowest free
            if (!busy[i]) begin
                slot_found = 1'b1;
                disp_slot  = ooo_pkg::rs_slot_t'(i);
            end
        end
        if (!slot_found && issue_fire) begin
            slot_found = 1'b1; // reuse the slot leaving this cycle
            disp_slot  = issue_slot;
        end
    end

    assign dispatch_ready = slot_found && !rob_full;
    assign dispatch_fire  = dispatch_valid && dispatch_ready && !stall && !squash;

    always_comb begin
        for (int i = 0; i < `RS_LEN; i++) begin
            wr_en[i] = dispatch_fire && (disp_slot == ooo_pkg::rs_slot_t'(i));
            clear[i] = issue_fire && (issue_slot == ooo_pkg::rs_slot_t'(i));
        end
    end

endmodule

// File: hw/dispatch_issue_top.sv
// dispatch and issue top, rob tag ring + map table + reservation station
// single dispatch and single issue per cycle
// retire only while the rob holds at least one tag
// register file, execute and cdb driver live outside

`timescale 1ns/10ps

module dispatch_issue_top (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                squash,
    input  logic                stall,
    input  logic                is_stall,
    // dispatch
    input  logic                dispatch_valid,
    input  ooo_pkg::alu_op_t    dispatch_op,
    input  ooo_pkg::arch_reg_t  dispatch_rs1,
    input  ooo_pkg::arch_reg_t  dispatch_rs2,
    input  ooo_pkg::arch_reg_t  dispatch_rd,
    input  ooo_pkg::xlen_t      dispatch_rs1_value,
    input  ooo_pkg::xlen_t      dispatch_rs2_value,
    output logic                dispatch_ready,
    output ooo_pkg::rob_tag_t   dispatch_rob_tag,
    // common data bus
    input  logic                cdb_valid,
    input  ooo_pkg::rob_tag_t   cdb_tag,
    input  ooo_pkg::xlen_t      cdb_value,
    input  logic                retire,
    // issue
    output logic                issue_valid,
    output ooo_pkg::alu_op_t    issue_op,
    output ooo_pkg::arch_reg_t  issue_rd,
    output ooo_pkg::rob_tag_t   issue_rob_tag,
    output ooo_pkg::xlen_t      issue_rs1_value,
    output ooo_pkg::xlen_t      issue_rs2_value
);

    ooo_pkg::rob_tag_t    head_tag;
    logic                 rob_full;
    logic                 dispatch_fire;     // accepted dispatch, from rs
    ooo_pkg::map_entry_t  rs1_map, rs2_map;

    // the tail tag is both the next rob tag and the reported dispatch tag
    rob_tag_ring rob_tag_ring_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .squash    (squash),
        .alloc     (dispatch_fire),
        .retire    (retire),
        .alloc_tag (dispatch_rob_tag),
        .head_tag  (head_tag),
        .rob_full  (rob_full)
    );

    map_table map_table_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .squash        (squash),
        .dispatch_fire (dispatch_fire),
        .dispatch_rs1  (dispatch_rs1),
        .dispatch_rs2  (dispatch_rs2),
        .dispatch_rd   (dispatch_rd),
        .alloc_tag     (dispatch_rob_tag),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .rs1_map       (rs1_map),
        .rs2_map       (rs2_map)
    );

    rs rs_inst (
        .clock (clock), .arst_n (arst_n), .squash (squash),
        .stall (stall), .is_stall (is_stall),
        .dispatch_valid (dispatch_valid), .dispatch_op (dispatch_op),
        .dispatch_rs1 (dispatch_rs1), .dispatch_rs2 (dispatch_rs2),
        .dispatch_rd (dispatch_rd),
        .dispatch_rs1_value (dispatch_rs1_value),
        .dispatch_rs2_value (dispatch_rs2_value),
        .rs1_map (rs1_map), .rs2_map (rs2_map),
        .alloc_tag (dispatch_rob_tag), .head_tag (head_tag), .rob_full (rob_full),
        .cdb_valid (cdb_valid), .cdb_tag (cdb_tag), .cdb_value (cdb_value),
        .dispatch_fire (dispatch_fire), .dispatch_ready (dispatch_ready),
        .issue_valid (issue_valid), .issue_op (issue_op), .issue_rd (issue_rd),
        .issue_rob_tag (issue_rob_tag),
        .issue_rs1_value (issue_rs1_value), .issue_rs2_value (issue_rs2_value)
    );

endmodule

// File: bench/tb_dispatch_issue.sv
// plays register file, cdb driver and retire source around dispatch_issue_top
// model keyed by rob tag and compared on every rising edge after reset
// cdb only carries tags of dispatched producers
// retire only while tags are live

`timescale 1ns/10ps

`include "ooo_config.svh"

module tb_dispatch_issue;

    localparam int TIMEOUT_CYCLES = 2000; // stimulus stays well under 200 cycles

    logic                clock, arst_n, squash, stall, is_stall, retire;
    logic                dispatch_valid, dispatch_ready, cdb_valid, issue_valid;
    ooo_pkg::alu_op_t    dispatch_op, issue_op;
    ooo_pkg::arch_reg_t  dispatch_rs1, dispatch_rs2, dispatch_rd, issue_rd;
    ooo_pkg::xlen_t      dispatch_rs1_value, dispatch_rs2_value, cdb_value;
    ooo_pkg::xlen_t      issue_rs1_value, issue_rs2_value;
    ooo_pkg::rob_tag_t   dispatch_rob_tag, cdb_tag, issue_rob_tag;

    // model state
    ooo_pkg::xlen_t      rf      [`ARCH_REGS];
    logic                reg_pend[`ARCH_REGS];
    ooo_pkg::rob_tag_t   reg_tag [`ARCH_REGS];
    logic                in_rs   [`ROB_LEN]; // dispatched and not yet issued
    ooo_pkg::alu_op_t    m_op    [`ROB_LEN];
    ooo_pkg::arch_reg_t  m_rd    [`ROB_LEN];
    ooo_pkg::operand_t   m_src   [`ROB_LEN][2];
    ooo_pkg::rob_tag_t   m_head, m_tail, t0, t1, t2, t3, t4, tx;
    int                  m_count, errors, checks, cycles;

    dispatch_issue_top dispatch_issue_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s got %h expected %h at cycle %0d", name, got, exp, cycles);
        end
    endtask

    // expected operand for a source at dispatch from the model rename state
    function automatic ooo_pkg::operand_t dispatch_operand(input ooo_pkg::arch_reg_t r);
        ooo_pkg::operand_t o;
        o.ready = 1'b1;
        o.tag   = reg_tag[r];
        o.value = rf[r];
        if (r != '0 && reg_pend[r]) begin
            o.ready = cdb_valid && (cdb_tag == reg_tag[r]); // woken in dispatch cycle
            o.value = cdb_value;
        end
        return o;
    endfunction

    function automatic logic src_hit(input ooo_pkg::rob_tag_t t, input int k);
        return !m_src[t][k].ready && cdb_valid && (cdb_tag == m_src[t][k].tag);
    endfunction

    function automatic logic entry_ready(input ooo_pkg::rob_tag_t t);
        return in_rs[t] && (m_src[t][0].ready || src_hit(t, 0))
                        && (m_src[t][1].ready || src_hit(t, 1));
    endfunction

    //////////////////////////////
    // compare
    //////////////////////////////

    always @(posedge clock) begin : compare
        ooo_pkg::rob_tag_t  t, oldest;
        ooo_pkg::operand_t  o1, o2;
        logic               found, fire;
        int                 occ;
        if (arst_n) begin
            found  = 1'b0;
            oldest = '0;
            occ    = 0;
            for (int k = 0; k < `ROB_LEN; k++) begin
                t = m_head + ooo_pkg::rob_tag_t'(k); // walk upward from head
                if (in_rs[t])
                    occ++;
                if (!found && entry_ready(t)) begin
                    found  = 1'b1;
                    oldest = t;
                end
            end
            expect_eq("dispatch_ready", dispatch_ready,
                      (occ < `RS_LEN || (found && !is_stall)) && m_count < `ROB_LEN);
            expect_eq("dispatch_rob_tag", dispatch_rob_tag, m_tail);
            expect_eq("issue_valid", issue_valid, found && !is_stall);
            fire = dispatch_valid && dispatch_ready && !stall && !squash;
            o1   = dispatch_operand(dispatch_rs1); // before this edge's updates
            o2   = dispatch_operand(dispatch_rs2);
            if (issue_valid && found) begin
                expect_eq("issue_rob_tag", issue_rob_tag, oldest);
                expect_eq("issue_op", issue_op, m_op[oldest]);
                expect_eq("issue_rd", issue_rd, m_rd[oldest]);
                expect_eq("issue_rs1_value", issue_rs1_value,
                          src_hit(oldest, 0) ? cdb_value : m_src[oldest][0].value);
                expect_eq("issue_rs2_value", issue_rs2_value,
                          src_hit(oldest, 1) ? cdb_value : m_src[oldest][1].value);
                in_rs[oldest] = 1'b0;
            end
            if (cdb_valid) begin
                for (int i = 0; i < `ROB_LEN; i++)
                    for (int k = 0; k < 2; k++)
                        if (in_rs[i] && src_hit(ooo_pkg::rob_tag_t'(i), k)) begin
                            m_src[i][k].ready = 1'b1;
                            m_src[i][k].value = cdb_value;
                        end
                for (int r = 1; r < `ARCH_REGS; r++)
                    if (reg_pend[r] && reg_tag[r] == cdb_tag) begin
                        reg_pend[r] = 1'b0; // write-back into the register file
                        rf[r]       = cdb_value;
                    end
            end
            if (fire) begin
                in_rs[m_tail]    = 1'b1;
                m_op[m_tail]     = dispatch_op;
                m_rd[m_tail]     = dispatch_rd;
                m_src[m_tail][0] = o1;
                m_src[m_tail][1] = o2;
                if (dispatch_rd != '0) begin
                    reg_pend[dispatch_rd] = 1'b1; // beats the cdb clear above
                    reg_tag[dispatch_rd]  = m_tail;
                end
                m_tail++;
                m_count++;
            end
            if (retire) begin
                m_head++;
                m_count--;
            end
            if (squash) begin
                in_rs    = '{default: 1'b0};
                reg_pend = '{default: 1'b0};
                m_head   = '0;
                m_tail   = '0;
                m_count  = 0;
            end
        end
    end

    always @(posedge clock) begin : watchdog
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////
    // stimulus on falling edges
    //////////////////////////////

    task automatic send(input ooo_pkg::alu_op_t op, input ooo_pkg::arch_reg_t a,
                        input ooo_pkg::arch_reg_t b, input ooo_pkg::arch_reg_t d,
                        output ooo_pkg::rob_tag_t tag);
        dispatch_valid     = 1'b1;
        dispatch_op        = op;
        dispatch_rs1       = a;
        dispatch_rs2       = b;
        dispatch_rd        = d;
        dispatch_rs1_value = rf[a];
        dispatch_rs2_value = rf[b];
        do
            @(posedge clock);
        while (!(dispatch_ready && !stall && !squash));
        tag = dispatch_rob_tag;
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    task automatic broadcast(input ooo_pkg::rob_tag_t tag, input ooo_pkg::xlen_t value);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_value = value;
        @(negedge clock);
        cdb_valid = 1'b0;
    endtask

    task automatic retire_tags(input int n);
        repeat (n) begin
            if (m_count == 0) begin
                errors++;
                $display("retire requested with no tag in flight");
            end
            retire = 1'b1;
            @(negedge clock);
            retire = 1'b0;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clock);
    endtask

    initial begin
        void'($urandom(56233));
        {squash, stall, is_stall, retire, dispatch_valid, cdb_valid} = '0;
        {dispatch_op, dispatch_rs1, dispatch_rs2, dispatch_rd} = '0;
        {dispatch_rs1_value, dispatch_rs2_value, cdb_tag, cdb_value} = '0;
        {m_head, m_tail, m_count, errors, checks, cycles} = '0;
        in_rs    = '{default: 1'b0};
        reg_pend = '{default: 1'b0};
        rf[0]    = '0; // zero register
        for (int r = 1; r < `ARCH_REGS; r++)
            rf[r] = $urandom;
        arst_n = 1'b0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // independent ops held back and drained oldest first
        is_stall = 1'b1;
        send(ooo_pkg::ALU_ADD, 8, 2, 5, t0);
        send(ooo_pkg::ALU_SUB, 3, 4, 9, t1);
        send(ooo_pkg::ALU_AND, 6, 1, 2, t2);
        is_stall = 1'b0;
        idle(1); // t0 leaves slot 0
        is_stall = 1'b1;
        send(ooo_pkg::ALU_XOR, 6, 7, 10, tx); // youngest op lands in slot 0
        idle(2);
        is_stall = 1'b0;
        idle(4);

        // dependents wait for both producers and forward in the broadcast cycle
        send(ooo_pkg::ALU_XOR, 5, 9, 12, t3);
        idle(2);
        broadcast(t0, $urandom);
        cdb_valid = 1'b1; // t1 on the cdb while a reader of r9 dispatches
        cdb_tag   = t1;
        cdb_value = $urandom;
        send(ooo_pkg::ALU_ADD, 9, 0, 13, t4);
        cdb_valid = 1'b0;
        broadcast(t2, $urandom);
        broadcast(t3, $urandom);
        broadcast(t4, $urandom);
        idle(3);
        retire_tags(6);

        // rs full under is_stall and refill of the slot issued in the same cycle
        is_stall = 1'b1;
        for (int i = 0; i < 4; i++)
            send(ooo_pkg::alu_op_t'(i), ooo_pkg::arch_reg_t'(1 + i),
                 ooo_pkg::arch_reg_t'(2 + i), ooo_pkg::arch_reg_t'(14 + i), tx);
        idle(3);
        is_stall = 1'b0;
        send(ooo_pkg::ALU_SUB, 9, 11, 25, tx); // no free slot so it takes the issuing one
        idle(5);
        // eight tags unretired fill the rob
        for (int i = 0; i < 3; i++)
            send(ooo_pkg::ALU_ADD, 7, 8, ooo_pkg::arch_reg_t'(18 + i), tx);
        idle(3);
        retire_tags(8);

        // stall keeps a valid op waiting and takes no tag
        stall          = 1'b1;
        dispatch_valid = 1'b1;
        idle(2);
        stall          = 1'b0;
        dispatch_valid = 1'b0;

        // r0 destination creates no dependency
        send(ooo_pkg::ALU_SUB, 1, 2, 0, tx);
        send(ooo_pkg::ALU_ADD, 0, 3, 22, tx);
        idle(3);

        // squash drops a held ready op and tags restart at 0
        is_stall = 1'b1;
        send(ooo_pkg::ALU_XOR, 1, 2, 23, tx);
        squash = 1'b1;
        idle(1);
        squash   = 1'b0;
        is_stall = 1'b0;
        idle(3);
        send(ooo_pkg::ALU_AND, 14, 4, 24, tx); // r14 rename dropped by squash
        expect_eq("dispatch_rob_tag", tx, '0);
        idle(4);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: files.f
+incdir+hw
hw/ooo_pkg.sv
hw/rob_tag_ring.sv
hw/map_table.sv
hw/rs_entry.sv
hw/rs.sv
hw/dispatch_issue_top.sv
bench/tb_dispatch_issue.sv

// File: Bender.yml
package:
  name: dispatch_issue

sources:
  - include_dirs:
      - hw
    files:
      - hw/ooo_pkg.sv
      - hw/rob_tag_ring.sv
      - hw/map_table.sv
      - hw/rs_entry.sv
      - hw/rs.sv
      - hw/dispatch_issue_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_dispatch_issue.sv
